//--- common/control_pkg.sv
package control_pkg;

  // Instruction field codes
  localparam logic [5:0] OPCODE_R     = 6'h00;
  localparam logic [5:0] OPCODE_J     = 6'h02;
  localparam logic [5:0] OPCODE_JAL   = 6'h03;
  localparam logic [5:0] OPCODE_BEQ   = 6'h04;
  localparam logic [5:0] OPCODE_BNE   = 6'h05;
  localparam logic [5:0] OPCODE_BLE   = 6'h06;
  localparam logic [5:0] OPCODE_BGT   = 6'h07;
  localparam logic [5:0] OPCODE_ADDI  = 6'h08;
  localparam logic [5:0] OPCODE_ADDIU = 6'h09;
  localparam logic [5:0] OPCODE_SLTI  = 6'h0a;
  localparam logic [5:0] OPCODE_LUI   = 6'h0f;
  localparam logic [5:0] OPCODE_LB    = 6'h20;
  localparam logic [5:0] OPCODE_LH    = 6'h21;
  localparam logic [5:0] OPCODE_LW    = 6'h23;
  localparam logic [5:0] OPCODE_SB    = 6'h28;
  localparam logic [5:0] OPCODE_SH    = 6'h29;
  localparam logic [5:0] OPCODE_SW    = 6'h2b;

  localparam logic [5:0] FUNCT_SLL  = 6'h00;
  localparam logic [5:0] FUNCT_SRL  = 6'h02;
  localparam logic [5:0] FUNCT_SRA  = 6'h03;
  localparam logic [5:0] FUNCT_SLLV = 6'h04;
  localparam logic [5:0] FUNCT_SRAV = 6'h07;
  localparam logic [5:0] FUNCT_JR   = 6'h08;
  localparam logic [5:0] FUNCT_MFHI = 6'h10;
  localparam logic [5:0] FUNCT_MFLO = 6'h12;
  localparam logic [5:0] FUNCT_MULT = 6'h18;
  localparam logic [5:0] FUNCT_DIV  = 6'h1a;
  localparam logic [5:0] FUNCT_ADD  = 6'h20;
  localparam logic [5:0] FUNCT_SUB  = 6'h22;
  localparam logic [5:0] FUNCT_AND  = 6'h24;
  localparam logic [5:0] FUNCT_SLT  = 6'h2a;

  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_SLT,
    OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRAV,
    OP_MULT, OP_DIV, OP_MFHI, OP_MFLO,
    OP_JR, OP_J, OP_JAL,
    OP_ADDI, OP_ADDIU, OP_SLTI, OP_LUI,
    OP_BEQ, OP_BNE, OP_BLE, OP_BGT,
    OP_LB, OP_LH, OP_LW,
    OP_SB, OP_SH, OP_SW,
    OP_ILLEGAL
  } op_kind_t;

  typedef struct packed {
    op_kind_t kind;
    logic     traps_overflow;
  } decoded_instr_t;

  typedef enum logic [5:0] {
    FETCH        = 6'h01,
    FETCH_WAIT   = 6'h02,
    DECODE       = 6'h03,
    // Execute, one per instruction
    ADD   = 6'h04, SUB   = 6'h05, AND   = 6'h06, SLT  = 6'h07,
    SLL   = 6'h08, SRL   = 6'h09, SRA   = 6'h0a, SLLV = 6'h0b, SRAV = 6'h0c,
    MULT  = 6'h0d, DIV   = 6'h0e, MFHI  = 6'h0f, MFLO = 6'h10,
    JR    = 6'h11, J     = 6'h12, JAL   = 6'h13,
    ADDI  = 6'h14, ADDIU = 6'h15, SLTI  = 6'h16, LUI  = 6'h17,
    BEQ   = 6'h18, BNE   = 6'h19, BLE   = 6'h1a, BGT  = 6'h1b,
    LB    = 6'h1c, LH    = 6'h1d, LW    = 6'h1e,
    SB    = 6'h1f, SH    = 6'h20, SW    = 6'h21,
    // Completion
    ALU_WB       = 6'h22,
    SLT_WB       = 6'h23,
    SHIFT_WB     = 6'h24,
    IMM_WB       = 6'h25,
    SLTI_WB      = 6'h26,
    LOAD_WAIT    = 6'h27,
    LOAD_WB      = 6'h28,
    STORE_WAIT   = 6'h29,
    MULT_WAIT    = 6'h2a,
    MULT_RELEASE = 6'h2b,
    MULT_END     = 6'h2c,
    DIV_WAIT     = 6'h2d,
    DIV_RELEASE  = 6'h2e,
    DIV_END      = 6'h2f,
    EXCEPTION    = 6'h30,
    EXC_OVERFLOW = 6'h31,
    EXC_DIV_ZERO = 6'h32,
    EXC_ILLEGAL  = 6'h33,
    EXC_WAIT     = 6'h34,
    EXC_END      = 6'h35
  } control_state_t;

  typedef enum logic [1:0] {
    NONE,
    OVERFLOW,
    DIV_ZERO,
    ILLEGAL
  } exc_cause_t;

  localparam logic [2:0] ALU_OP_ADD = 3'd1;
  localparam logic [2:0] ALU_OP_SUB = 3'd2;
  localparam logic [2:0] ALU_OP_AND = 3'd3;
  localparam logic [2:0] ALU_OP_SLT = 3'd7;

  localparam logic [2:0] SHIFT_OP_LEFT          = 3'd2;
  localparam logic [2:0] SHIFT_OP_RIGHT_LOGICAL = 3'd3;
  localparam logic [2:0] SHIFT_OP_RIGHT_ARITH   = 3'd4;

  // Exception vector comes back through memory
  localparam logic [2:0] PC_SRC_EXC_VECTOR = 3'd0;
  localparam logic [2:0] PC_SRC_ALU        = 3'd1;
  localparam logic [2:0] PC_SRC_ALU_OUT    = 3'd3;
  localparam logic [2:0] PC_SRC_REG_A      = 3'd4;
  localparam logic [2:0] PC_SRC_JUMP       = 3'd5;

  localparam logic [2:0] IORD_PC       = 3'd0;
  localparam logic [2:0] IORD_OVERFLOW = 3'd2;
  localparam logic [2:0] IORD_DIV_ZERO = 3'd3;
  localparam logic [2:0] IORD_ILLEGAL  = 3'd4;
  localparam logic [2:0] IORD_ALU_OUT  = 3'd5;

  localparam logic [2:0] REG_DST_RT = 3'd0;
  localparam logic [2:0] REG_DST_RD = 3'd1;
  localparam logic [2:0] REG_DST_RA = 3'd2;

  localparam logic [3:0] MEM_TO_REG_ALU_OUT = 4'd0;
  localparam logic [3:0] MEM_TO_REG_MEM     = 4'd1;
  localparam logic [3:0] MEM_TO_REG_PC      = 4'd2;
  localparam logic [3:0] MEM_TO_REG_SLT     = 4'd3;
  localparam logic [3:0] MEM_TO_REG_HI      = 4'd4;
  localparam logic [3:0] MEM_TO_REG_LO      = 4'd5;
  localparam logic [3:0] MEM_TO_REG_SHIFT   = 4'd10;

  localparam logic [1:0] BRANCH_LE = 2'd0;
  localparam logic [1:0] BRANCH_GT = 2'd1;
  localparam logic [1:0] BRANCH_EQ = 2'd2;
  localparam logic [1:0] BRANCH_NE = 2'd3;

  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  typedef struct packed {
    logic [1:0] alu_srca;
    logic [1:0] alu_srcb;
    logic [2:0] alu_op;
  } alu_ctrl_t;

  typedef struct packed {
    logic [1:0] shift_srca;
    logic [1:0] shift_srcb;
    logic [2:0] shift;
  } shift_ctrl_t;

  typedef struct packed {
    logic [2:0] iord;
    logic       write_mem;
    logic [1:0] load_type;
    logic [1:0] store_type;
  } mem_ctrl_t;

  typedef struct packed {
    logic       reg_write;
    logic [2:0] reg_dst;
    logic [3:0] mem_to_reg;
    logic       hi_ctrl;
    logic       lo_ctrl;
  } wb_ctrl_t;

  typedef struct packed {
    logic       ir_write;
    logic       pc_write;
    logic       pc_write_cond;
    logic       epc_write;
    logic [2:0] pc_src;
    logic [1:0] branch_type;
  } pc_ctrl_t;

  typedef struct packed {
    alu_ctrl_t   alu;
    shift_ctrl_t shifter;
    mem_ctrl_t   mem;
    wb_ctrl_t    wb;
    pc_ctrl_t    pc;
  } ctrl_word_t;

endpackage

//--- decode/instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
  input  logic [5:0]                  opcode,
  input  logic [5:0]                  funct,
  output control_pkg::decoded_instr_t decoded
);
  import control_pkg::*;

  op_kind_t kind;

  always_comb begin
    kind = OP_ILLEGAL;
    case (opcode)
      OPCODE_R: begin
        // R type, funct picks the operation
        case (funct)
          FUNCT_ADD:  kind = OP_ADD;
          FUNCT_SUB:  kind = OP_SUB;
          FUNCT_AND:  kind = OP_AND;
          FUNCT_SLT:  kind = OP_SLT;
          FUNCT_SLL:  kind = OP_SLL;
          FUNCT_SRL:  kind = OP_SRL;
          FUNCT_SRA:  kind = OP_SRA;
          FUNCT_SLLV: kind = OP_SLLV;
          FUNCT_SRAV: kind = OP_SRAV;
          FUNCT_MULT: kind = OP_MULT;
          FUNCT_DIV:  kind = OP_DIV;
          FUNCT_MFHI: kind = OP_MFHI;
          FUNCT_MFLO: kind = OP_MFLO;
          FUNCT_JR:   kind = OP_JR;
          default:    kind = OP_ILLEGAL;
        endcase
      end
      OPCODE_ADDI:  kind = OP_ADDI;
      OPCODE_ADDIU: kind = OP_ADDIU;
      OPCODE_SLTI:  kind = OP_SLTI;
      OPCODE_LUI:   kind = OP_LUI;
      OPCODE_BEQ:   kind = OP_BEQ;
      OPCODE_BNE:   kind = OP_BNE;
      OPCODE_BLE:   kind = OP_BLE;
      OPCODE_BGT:   kind = OP_BGT;
      OPCODE_LB:    kind = OP_LB;
      OPCODE_LH:    kind = OP_LH;
      OPCODE_LW:    kind = OP_LW;
      OPCODE_SB:    kind = OP_SB;
      OPCODE_SH:    kind = OP_SH;
      OPCODE_SW:    kind = OP_SW;
      OPCODE_J:     kind = OP_J;
      OPCODE_JAL:   kind = OP_JAL;
      default:      kind = OP_ILLEGAL;
    endcase
  end

  assign decoded.kind = kind;
  // Signed arithmetic only, addiu never traps
  assign decoded.traps_overflow = (kind == OP_ADD) || (kind == OP_SUB) || (kind == OP_ADDI);

endmodule

//--- execute/control_sequencer.sv
`timescale 1ns/1ns

module control_sequencer (
  input  logic                        clock,
  input  logic                        reset,
  input  control_pkg::decoded_instr_t decoded,
  input  logic                        overflow,
  input  logic                        div_zero,
  input  logic                        mult_ack,
  input  logic                        div_ack,
  output logic                        mult_req,
  output logic                        div_req,
  output control_pkg::control_state_t state,
  output control_pkg::control_state_t next_state
);
  import control_pkg::*;

  decoded_instr_t instr_q;
  exc_cause_t     cause_q;
  control_state_t first_state;
  logic           trap;

  // Execute state entered from decode
  always_comb begin
    case (decoded.kind)
      OP_ADD:   first_state = ADD;
      OP_SUB:   first_state = SUB;
      OP_AND:   first_state = AND;
      OP_SLT:   first_state = SLT;
      OP_SLL:   first_state = SLL;
      OP_SRL:   first_state = SRL;
      OP_SRA:   first_state = SRA;
      OP_SLLV:  first_state = SLLV;
      OP_SRAV:  first_state = SRAV;
      OP_MULT:  first_state = MULT;
      OP_DIV:   first_state = DIV;
      OP_MFHI:  first_state = MFHI;
      OP_MFLO:  first_state = MFLO;
      OP_JR:    first_state = JR;
      OP_J:     first_state = J;
      OP_JAL:   first_state = JAL;
      OP_ADDI:  first_state = ADDI;
      OP_ADDIU: first_state = ADDIU;
      OP_SLTI:  first_state = SLTI;
      OP_LUI:   first_state = LUI;
      OP_BEQ:   first_state = BEQ;
      OP_BNE:   first_state = BNE;
      OP_BLE:   first_state = BLE;
      OP_BGT:   first_state = BGT;
      OP_LB:    first_state = LB;
      OP_LH:    first_state = LH;
      OP_LW:    first_state = LW;
      OP_SB:    first_state = SB;
      OP_SH:    first_state = SH;
      OP_SW:    first_state = SW;
      default:  first_state = EXCEPTION;
    endcase
  end

  // Overflow only counts in the execute cycle of a trapping op
  assign trap = instr_q.traps_overflow && overflow;

  always_comb begin
    next_state = state;
    case (state)
      FETCH:                    next_state = FETCH_WAIT;
      FETCH_WAIT:               next_state = DECODE;
      DECODE:                   next_state = first_state;
      ADD, SUB:                 next_state = trap ? EXCEPTION : ALU_WB;
      AND:                      next_state = ALU_WB;
      SLT:                      next_state = SLT_WB;
      SLL, SRL, SRA, SLLV, SRAV: next_state = SHIFT_WB;
      ADDI:                     next_state = trap ? EXCEPTION : IMM_WB;
      ADDIU, LUI:               next_state = IMM_WB;
      SLTI:                     next_state = SLTI_WB;
      LB, LH, LW:               next_state = LOAD_WAIT;
      LOAD_WAIT:                next_state = LOAD_WB;
      SB, SH, SW:               next_state = STORE_WAIT;
      MULT:                     next_state = MULT_WAIT;
      MULT_WAIT:                if (mult_ack) next_state = MULT_RELEASE;
      MULT_RELEASE:             if (!mult_ack) next_state = MULT_END;
      DIV:                      next_state = DIV_WAIT;
      DIV_WAIT:                 if (div_ack) next_state = DIV_RELEASE;
      DIV_RELEASE: begin
        // Finish the handshake before taking the trap
        if (!div_ack) begin
          next_state = (cause_q == DIV_ZERO) ? EXCEPTION : DIV_END;
        end
      end
      EXCEPTION: begin
        case (cause_q)
          OVERFLOW: next_state = EXC_OVERFLOW;
          DIV_ZERO: next_state = EXC_DIV_ZERO;
          default:  next_state = EXC_ILLEGAL;
        endcase
      end
      EXC_OVERFLOW, EXC_DIV_ZERO, EXC_ILLEGAL: next_state = EXC_WAIT;
      EXC_WAIT:                 next_state = EXC_END;
      // Write-backs, branches, jumps and the END states all return to fetch
      default:                  next_state = FETCH;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= FETCH;
      cause_q <= NONE;
    end else begin
      state <= next_state;
      case (state)
        FETCH:         cause_q <= NONE;
        DECODE:        if (decoded.kind == OP_ILLEGAL) cause_q <= ILLEGAL;
        ADD, SUB, ADDI: if (trap) cause_q <= OVERFLOW;
        DIV_WAIT:      if (div_ack && div_zero) cause_q <= DIV_ZERO;
        default:       cause_q <= cause_q;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == DECODE) begin
      instr_q <= decoded;
    end
  end

  assign mult_req = (state == MULT) || (state == MULT_WAIT);
  assign div_req = (state == DIV) || (state == DIV_WAIT);

endmodule

//--- result/control_word_gen.sv
`timescale 1ns/1ns

module control_word_gen (
  input  logic                        clock,
  input  logic                        reset,
  input  control_pkg::control_state_t next_state,
  output control_pkg::ctrl_word_t     ctrl
);
  import control_pkg::*;

  ctrl_word_t word;

  // Patterns list fields in struct order
  // alu and shifter: srca, srcb, op
  // mem: iord, write_mem, load_type, store_type
  // wb: reg_write, reg_dst, mem_to_reg, hi, lo
  // pc: ir_write, pc_write, pc_write_cond, epc_write, pc_src, branch_type
  always_comb begin
    word = '0;
    case (next_state)
      FETCH: begin
        word.alu = '{2'd0, 2'd1, ALU_OP_ADD};
        word.mem.iord = IORD_PC;
        word.pc = '{1'b1, 1'b1, 1'b0, 1'b0, PC_SRC_ALU, 2'd0};
      end
      // Branch target computed early
      DECODE: word.alu = '{2'd0, 2'd3, ALU_OP_ADD};

      ADD:          word.alu = '{2'd1, 2'd0, ALU_OP_ADD};
      SUB:          word.alu = '{2'd1, 2'd0, ALU_OP_SUB};
      AND:          word.alu = '{2'd1, 2'd0, ALU_OP_AND};
      SLT:          word.alu = '{2'd1, 2'd0, ALU_OP_SLT};
      ADDI, ADDIU:  word.alu = '{2'd1, 2'd2, ALU_OP_ADD};
      SLTI:         word.alu = '{2'd1, 2'd2, ALU_OP_SLT};

      SLL:  word.shifter = '{2'd1, 2'd0, SHIFT_OP_LEFT};
      SRL:  word.shifter = '{2'd1, 2'd0, SHIFT_OP_RIGHT_LOGICAL};
      SRA:  word.shifter = '{2'd1, 2'd0, SHIFT_OP_RIGHT_ARITH};
      SLLV: word.shifter = '{2'd0, 2'd1, SHIFT_OP_LEFT};
      SRAV: word.shifter = '{2'd0, 2'd1, SHIFT_OP_RIGHT_ARITH};
      LUI:  word.shifter = '{2'd2, 2'd2, SHIFT_OP_LEFT};

      ALU_WB:   word.wb = '{1'b1, REG_DST_RD, MEM_TO_REG_ALU_OUT, 1'b0, 1'b0};
      SLT_WB:   word.wb = '{1'b1, REG_DST_RD, MEM_TO_REG_SLT, 1'b0, 1'b0};
      SHIFT_WB: word.wb = '{1'b1, REG_DST_RD, MEM_TO_REG_SHIFT, 1'b0, 1'b0};
      IMM_WB:   word.wb = '{1'b1, REG_DST_RT, MEM_TO_REG_ALU_OUT, 1'b0, 1'b0};
      SLTI_WB:  word.wb = '{1'b1, REG_DST_RT, MEM_TO_REG_SLT, 1'b0, 1'b0};
      LOAD_WB:  word.wb = '{1'b1, REG_DST_RT, MEM_TO_REG_MEM, 1'b0, 1'b0};
      MFHI:     word.wb = '{1'b1, REG_DST_RD, MEM_TO_REG_HI, 1'b0, 1'b0};
      MFLO:     word.wb = '{1'b1, REG_DST_RD, MEM_TO_REG_LO, 1'b0, 1'b0};
      MULT_END, DIV_END: begin
        word.wb.hi_ctrl = 1'b1;
        word.wb.lo_ctrl = 1'b1;
      end

      LB: word.mem = '{IORD_ALU_OUT, 1'b0, SIZE_BYTE, 2'd0};
      LH: word.mem = '{IORD_ALU_OUT, 1'b0, SIZE_HALF, 2'd0};
      LW: word.mem = '{IORD_ALU_OUT, 1'b0, SIZE_WORD, 2'd0};
      SB: word.mem = '{IORD_ALU_OUT, 1'b1, 2'd0, SIZE_BYTE};
      SH: word.mem = '{IORD_ALU_OUT, 1'b1, 2'd0, SIZE_HALF};
      SW: word.mem = '{IORD_ALU_OUT, 1'b1, 2'd0, SIZE_WORD};

      // Compare in the ALU, the datapath picks the outcome by branch_type
      BEQ: begin
        word.alu = '{2'd1, 2'd0, ALU_OP_SUB};
        word.pc = '{1'b0, 1'b0, 1'b1, 1'b0, PC_SRC_ALU_OUT, BRANCH_EQ};
      end
      BNE: begin
        word.alu = '{2'd1, 2'd0, ALU_OP_SUB};
        word.pc = '{1'b0, 1'b0, 1'b1, 1'b0, PC_SRC_ALU_OUT, BRANCH_NE};
      end
      BLE: begin
        word.alu = '{2'd1, 2'd0, ALU_OP_SLT};
        word.pc = '{1'b0, 1'b0, 1'b1, 1'b0, PC_SRC_ALU_OUT, BRANCH_LE};
      end
      BGT: begin
        word.alu = '{2'd1, 2'd0, ALU_OP_SLT};
        word.pc = '{1'b0, 1'b0, 1'b1, 1'b0, PC_SRC_ALU_OUT, BRANCH_GT};
      end

      JR: word.pc = '{1'b0, 1'b1, 1'b0, 1'b0, PC_SRC_REG_A, 2'd0};
      J:  word.pc = '{1'b0, 1'b1, 1'b0, 1'b0, PC_SRC_JUMP, 2'd0};
      JAL: begin
        word.wb = '{1'b1, REG_DST_RA, MEM_TO_REG_PC, 1'b0, 1'b0};
        word.pc = '{1'b0, 1'b1, 1'b0, 1'b0, PC_SRC_JUMP, 2'd0};
      end

      // EPC gets pc - 4
      EXCEPTION: begin
        word.alu = '{2'd0, 2'd1, ALU_OP_SUB};
        word.pc.epc_write = 1'b1;
      end
      EXC_OVERFLOW: word.mem.iord = IORD_OVERFLOW;
      EXC_DIV_ZERO: word.mem.iord = IORD_DIV_ZERO;
      EXC_ILLEGAL:  word.mem.iord = IORD_ILLEGAL;
      EXC_END:      word.pc = '{1'b0, 1'b1, 1'b0, 1'b0, PC_SRC_EXC_VECTOR, 2'd0};

      default: word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ctrl <= '0;
    end else begin
      ctrl <= word;
    end
  end

endmodule

//--- source/control_unit.sv
`timescale 1ns/1ns

module control_unit (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [5:0]                  opcode,
  input  logic [5:0]                  funct,
  input  logic                        overflow,
  input  logic                        div_zero,
  input  logic                        mult_ack,
  input  logic                        div_ack,
  output control_pkg::ctrl_word_t     ctrl,
  output control_pkg::control_state_t state,
  output logic                        mult_req,
  output logic                        div_req
);
  import control_pkg::*;

  decoded_instr_t decoded;
  control_state_t next_state;

  instr_decode decode_i (
    .opcode  (opcode),
    .funct   (funct),
    .decoded (decoded)
  );

  control_sequencer sequencer_i (
    .clock      (clock),
    .reset      (reset),
    .decoded    (decoded),
    .overflow   (overflow),
    .div_zero   (div_zero),
    .mult_ack   (mult_ack),
    .div_ack    (div_ack),
    .mult_req   (mult_req),
    .div_req    (div_req),
    .state      (state),
    .next_state (next_state)
  );

  // Word is registered from next_state so it lines up with state
  control_word_gen word_gen_i (
    .clock      (clock),
    .reset      (reset),
    .next_state (next_state),
    .ctrl       (ctrl)
  );

endmodule

//--- verif/control_unit_tb.sv
`timescale 1ns/1ns

module control_unit_tb;
  import control_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;

  logic           clock;
  logic           reset;
  logic [5:0]     opcode;
  logic [5:0]     funct;
  logic           overflow;
  logic           div_zero;
  logic           mult_ack = 1'b0;
  logic           div_ack = 1'b0;
  ctrl_word_t     ctrl;
  control_state_t state;
  logic           mult_req;
  logic           div_req;

  logic [5:0]     expected_path[$];
  int             errors = 0;
  int             instr_count = 0;
  logic           aborted = 1'b0;
  int unsigned    ack_countdown = 0;
  logic           release_seen = 1'b0;

  control_unit dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Ack responder for multiplier and divider
  // Only one request is open at a time
  always @(negedge clock) begin
    if (mult_ack || div_ack) begin
      // Drop ack one cycle after req goes low
      if (!mult_req && !div_req) begin
        release_seen <= 1'b1;
        if (release_seen) begin
          mult_ack <= 1'b0;
          div_ack <= 1'b0;
          release_seen <= 1'b0;
        end
      end
    end else if (ack_countdown > 1) begin
      ack_countdown <= ack_countdown - 1;
    end else if (ack_countdown == 1) begin
      ack_countdown <= 0;
      mult_ack <= mult_req;
      div_ack <= div_req;
    end else if (mult_req || div_req) begin
      ack_countdown <= 1 + ($urandom % 8);
    end
  end

  task automatic compare_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  // State, control word and handshake lines for one expected state
  task automatic verify_cycle(input logic [5:0] s);
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       hi_lo;
    logic [1:0] size;
    logic [1:0] branch;
    logic [2:0] iord;
    logic [2:0] alu_op;
    logic [2:0] shift_op;
    logic [3:0] wb_src;
    logic [2:0] dest;
    logic [2:0] pc_src;
    is_load = s inside {LB, LH, LW};
    is_store = s inside {SB, SH, SW};
    is_branch = s inside {BEQ, BNE, BLE, BGT};
    hi_lo = s inside {MULT_END, DIV_END};
    case (s)
      LB, SB:  size = SIZE_BYTE;
      LH, SH:  size = SIZE_HALF;
      LW, SW:  size = SIZE_WORD;
      default: size = 2'd0;
    endcase
    case (s)
      BEQ:     branch = BRANCH_EQ;
      BNE:     branch = BRANCH_NE;
      BLE:     branch = BRANCH_LE;
      BGT:     branch = BRANCH_GT;
      default: branch = 2'd0;
    endcase
    case (s)
      EXC_OVERFLOW: iord = IORD_OVERFLOW;
      EXC_DIV_ZERO: iord = IORD_DIV_ZERO;
      EXC_ILLEGAL:  iord = IORD_ILLEGAL;
      default:      iord = (is_load || is_store) ? IORD_ALU_OUT : IORD_PC;
    endcase
    // Arithmetic execute states and the pc + 4 in fetch
    case (s)
      FETCH, ADD, ADDI, ADDIU: alu_op = ALU_OP_ADD;
      SUB:                     alu_op = ALU_OP_SUB;
      AND:                     alu_op = ALU_OP_AND;
      SLT, SLTI:               alu_op = ALU_OP_SLT;
      default:                 alu_op = 3'd0;
    endcase
    case (s)
      SLL, SLLV: shift_op = SHIFT_OP_LEFT;
      SRL:       shift_op = SHIFT_OP_RIGHT_LOGICAL;
      SRA, SRAV: shift_op = SHIFT_OP_RIGHT_ARITH;
      default:   shift_op = 3'd0;
    endcase
    case (s)
      ALU_WB, IMM_WB:  wb_src = MEM_TO_REG_ALU_OUT;
      SLT_WB, SLTI_WB: wb_src = MEM_TO_REG_SLT;
      SHIFT_WB:        wb_src = MEM_TO_REG_SHIFT;
      LOAD_WB:         wb_src = MEM_TO_REG_MEM;
      MFHI:            wb_src = MEM_TO_REG_HI;
      MFLO:            wb_src = MEM_TO_REG_LO;
      JAL:             wb_src = MEM_TO_REG_PC;
      default:         wb_src = 4'd0;
    endcase
    // R type results go to rd, immediates and loads to rt
    case (s)
      ALU_WB, SLT_WB, SHIFT_WB, MFHI, MFLO: dest = REG_DST_RD;
      JAL:                                  dest = REG_DST_RA;
      default:                              dest = REG_DST_RT;
    endcase
    case (s)
      FETCH:              pc_src = PC_SRC_ALU;
      BEQ, BNE, BLE, BGT: pc_src = PC_SRC_ALU_OUT;
      JR:                 pc_src = PC_SRC_REG_A;
      J, JAL:             pc_src = PC_SRC_JUMP;
      default:            pc_src = PC_SRC_EXC_VECTOR;
    endcase
    compare_value("state", 64'(state), 64'(s));
    compare_value("ir_write", 64'(ctrl.pc.ir_write), 64'(s == FETCH));
    compare_value("pc_write", 64'(ctrl.pc.pc_write),
                  64'(s inside {FETCH, JR, J, JAL, EXC_END}));
    compare_value("reg_write", 64'(ctrl.wb.reg_write),
                  64'(s inside {ALU_WB, SLT_WB, SHIFT_WB, IMM_WB, SLTI_WB, LOAD_WB,
                                JAL, MFHI, MFLO}));
    compare_value("reg_dst", 64'(ctrl.wb.reg_dst), 64'(dest));
    compare_value("mem_to_reg", 64'(ctrl.wb.mem_to_reg), 64'(wb_src));
    compare_value("write_mem", 64'(ctrl.mem.write_mem), 64'(is_store));
    compare_value("store_type", 64'(ctrl.mem.store_type), 64'(is_store ? size : 2'd0));
    compare_value("load_type", 64'(ctrl.mem.load_type), 64'(is_load ? size : 2'd0));
    compare_value("iord", 64'(ctrl.mem.iord), 64'(iord));
    compare_value("pc_write_cond", 64'(ctrl.pc.pc_write_cond), 64'(is_branch));
    compare_value("branch_type", 64'(ctrl.pc.branch_type), 64'(branch));
    compare_value("pc_src", 64'(ctrl.pc.pc_src), 64'(pc_src));
    if (s inside {FETCH, ADD, SUB, AND, SLT, ADDI, ADDIU, SLTI}) begin
      compare_value("alu_op", 64'(ctrl.alu.alu_op), 64'(alu_op));
    end
    if (s inside {SLL, SRL, SRA, SLLV, SRAV}) begin
      compare_value("shift", 64'(ctrl.shifter.shift), 64'(shift_op));
    end
    compare_value("hi_ctrl", 64'(ctrl.wb.hi_ctrl), 64'(hi_lo));
    compare_value("lo_ctrl", 64'(ctrl.wb.lo_ctrl), 64'(hi_lo));
    compare_value("epc_write", 64'(ctrl.pc.epc_write), 64'(s == EXCEPTION));
    compare_value("mult_req", 64'(mult_req), 64'(s inside {MULT, MULT_WAIT}));
    compare_value("div_req", 64'(div_req), 64'(s inside {DIV, DIV_WAIT}));
    // A high ack in WAIT means the sequencer missed it
    if (s inside {MULT_WAIT, MULT_END}) begin
      compare_value("mult_ack", 64'(mult_ack), 64'd0);
    end
    if (s inside {DIV_WAIT, DIV_END}) begin
      compare_value("div_ack", 64'(div_ack), 64'd0);
    end
  endtask

  task automatic await_fetch();
    int waited;
    waited = 0;
    while (state != FETCH && waited < TIMEOUT_CYCLES) begin
      @(negedge clock);
      waited++;
    end
    if (state != FETCH) begin
      $display("Timeout: the sequencer did not return to FETCH within %0d cycles",
               TIMEOUT_CYCLES);
      errors++;
      aborted = 1'b1;
    end
  endtask

  // State codes up to the 00 terminator
  task automatic read_path(input int fd);
    logic [31:0] code;
    int          n;
    expected_path.delete();
    n = $fscanf(fd, "%h", code);
    while (n == 1 && code != 0 && expected_path.size() < 32) begin
      expected_path.push_back(code[5:0]);
      n = $fscanf(fd, "%h", code);
    end
  endtask

  task automatic run_instruction(input logic [5:0] op, input logic [5:0] fn,
                                 input logic ovf, input logic dz);
    logic [5:0] prev;
    int         waited;
    int         i;
    await_fetch();
    if (!aborted) begin
      opcode = op;
      funct = fn;
      overflow = ovf;
      div_zero = dz;
      @(negedge clock);
      verify_cycle(FETCH_WAIT);
      prev = FETCH_WAIT;
      for (i = 0; i < expected_path.size() && !aborted; i++) begin
        @(negedge clock);
        waited = 0;
        // WAIT and RELEASE last as long as the responder holds them
        while (prev inside {MULT_WAIT, MULT_RELEASE, DIV_WAIT, DIV_RELEASE} &&
               state == prev && waited < TIMEOUT_CYCLES) begin
          verify_cycle(prev);
          @(negedge clock);
          waited++;
        end
        if (waited >= TIMEOUT_CYCLES) begin
          $display("Timeout: the sequencer stayed in state 0x%0h for %0d cycles",
                   prev, TIMEOUT_CYCLES);
          errors++;
          aborted = 1'b1;
        end else begin
          verify_cycle(expected_path[i]);
          prev = expected_path[i];
        end
      end
    end
  endtask

  initial begin : stimulus
    int          fd;
    int          n;
    logic [31:0] opc;
    logic [31:0] fn;
    logic [31:0] ovf;
    logic [31:0] dz;
    void'($urandom(32'h2e74_b580));
    reset = 1'b1;
    opcode = 6'd0;
    funct = 6'd0;
    overflow = 1'b0;
    div_zero = 1'b0;
    repeat (2) @(negedge clock);
    reset = 1'b0;
    // First cycle out of reset
    compare_value("state", 64'(state), 64'(FETCH));
    compare_value("ctrl", 64'(ctrl), 64'd0);
    compare_value("mult_req", 64'(mult_req), 64'd0);
    compare_value("div_req", 64'(div_req), 64'd0);
    fd = $fopen("verif/control_unit_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/control_unit_testdata.txt");
      errors++;
    end else begin
      n = $fscanf(fd, "%h %h %h %h", opc, fn, ovf, dz);
      while (n == 4 && !aborted) begin
        read_path(fd);
        run_instruction(opc[5:0], fn[5:0], ovf[0], dz[0]);
        instr_count++;
        n = $fscanf(fd, "%h %h %h %h", opc, fn, ovf, dz);
      end
      $fclose(fd);
    end
    if (instr_count == 0) begin
      $display("No instructions were read from the test data");
      errors++;
    end
    $display("Ran %0d instructions with %0d errors", instr_count, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verif/control_unit_testdata.txt
00 20 0 0 03 04 22 01 00
00 22 0 0 03 05 22 01 00
00 24 0 0 03 06 22 01 00
00 2a 0 0 03 07 23 01 00
00 00 0 0 03 08 24 01 00
00 02 0 0 03 09 24 01 00
00 03 0 0 03 0a 24 01 00
00 04 0 0 03 0b 24 01 00
00 07 0 0 03 0c 24 01 00
00 18 0 0 03 0d 2a 2b 2c 01 00
00 1a 0 0 03 0e 2d 2e 2f 01 00
00 10 0 0 03 0f 01 00
00 12 0 0 03 10 01 00
00 08 0 0 03 11 01 00
02 00 0 0 03 12 01 00
03 00 0 0 03 13 01 00
08 00 0 0 03 14 25 01 00
09 00 0 0 03 15 25 01 00
0a 00 0 0 03 16 26 01 00
0f 00 0 0 03 17 25 01 00
04 00 0 0 03 18 01 00
05 00 0 0 03 19 01 00
06 00 0 0 03 1a 01 00
07 00 0 0 03 1b 01 00
20 00 0 0 03 1c 27 28 01 00
21 00 0 0 03 1d 27 28 01 00
23 00 0 0 03 1e 27 28 01 00
28 00 0 0 03 1f 29 01 00
29 00 0 0 03 20 29 01 00
2b 00 0 0 03 21 29 01 00
00 20 1 0 03 04 30 31 34 35 01 00
00 22 1 0 03 05 30 31 34 35 01 00
08 00 1 0 03 14 30 31 34 35 01 00
09 00 1 0 03 15 25 01 00
00 18 0 0 03 0d 2a 2b 2c 01 00
00 1a 0 1 03 0e 2d 2e 30 32 34 35 01 00
3f 00 0 0 03 30 33 34 35 01 00
00 3f 0 0 03 30 33 34 35 01 00
00 1a 0 0 03 0e 2d 2e 2f 01 00

//--- sim.f
common/control_pkg.sv
decode/instr_decode.sv
execute/control_sequencer.sv
result/control_word_gen.sv
source/control_unit.sv
verif/control_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ns --top-module control_unit_tb \
  -Mdir obj_dir -f sim.f

output=$(./obj_dir/Vcontrol_unit_tb)
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
exit 1
